// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ADC controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module adc_ctrl_tb \
    --Mdir obj_dir -o adc_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/adc_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== sim/adc_ctrl_props.sv ====
`timescale 1ns/100ps

// output protocol rules of the ADC controller
module adc_ctrl_props (
    input logic clk,
    input logic rst_l,
    input logic rd_en,
    input logic start,
    input logic busy,
    input logic sclk
);

    // result strobe is a single cycle
    rd_en_single: assert property (@(posedge clk) disable iff (!rst_l)
        rd_en |=> !rd_en)
        else $error("rd_en high for two cycles in a row");

    // start pin only inside a read cycle
    start_in_busy: assert property (@(posedge clk) disable iff (!rst_l)
        start |-> busy)
        else $error("start high while busy is low");

    // serial clock idles low between read cycles
    sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_l)
        !busy |-> !sclk)
        else $error("sclk high while busy is low");

endmodule

bind adc_ctrl_top adc_ctrl_props props (
    .clk   (clk),
    .rst_l (rst_l),
    .rd_en (rd_en),
    .start (start),
    .busy  (busy),
    .sclk  (sclk)
);

// ==== sim/adc_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "adc_cfg.svh"

// testbench for the two-channel ADC controller with a small behavioural ADC
module adc_ctrl_tb;
    import adc_pkg::*;

    localparam int TIMEOUT = 4000;  // clk cycles allowed for one whole read cycle

    logic      clk = 1'b0;
    logic      rst_l;
    logic      drdy;
    logic      dout;
    logic      sync;
    adc_cfg_t  wreg_command;
    chan_sel_t channel_choice;
    logic      din;
    logic      sclk;
    logic      nrst;
    logic      start;
    logic      busy;
    adc_word_t data_o;
    logic      channel;
    logic      rd_en;

    integer    seed = 32'hbaaa1dda;
    int        err_cnt = 0;         // wrong values
    int        fail_cnt = 0;        // timeouts, missing frames or results
    adc_word_t frames[$];           // din frames seen by the ADC model
    adc_word_t exp_data[$];         // words the model sent in send order
    logic      obs_ch[$];           // channel output at each rd_en

    int        start_w = 0;         // start pin width so far
    logic      start_q = 1'b0;
    logic      busy_q = 1'b0;
    logic      rd_q = 1'b0;

    always #4 clk = ~clk;           // 8 ns period

    adc_ctrl_top dut (.*);

    // expected register write frame from opcode, mux field and external config
    function automatic adc_word_t exp_write_frame(input logic ch, input adc_cfg_t cfg);
        return {`ADC_OP_WREG, 1'b0, ch, cfg};
    endfunction

    task automatic check_word(input string name, input adc_word_t exp, input adc_word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_sel(input string name, input chan_sel_t exp, input chan_sel_t act);
        if (act !== exp) begin
            $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic wait_busy_low(input int limit);
        int n;
        n = 0;
        while (busy !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("%0t: busy did not fall within %0d cycles", $time, limit);
            fail_cnt++;
        end
    endtask

    // behavioural ADC takes din on rising sclk and answers the start pulse with drdy and a word
    initial begin : adc_model
        logic        sclk_p;
        logic        start_p;
        logic        rd_active;
        int          cap_n;
        int          rd_bits;
        int          delay;
        adc_word_t   cap;
        adc_word_t   rd_word;
        logic [31:0] r;
        drdy = 1'b0;
        dout = 1'b0;
        sclk_p = 1'b0;
        start_p = 1'b0;
        rd_active = 1'b0;
        cap_n = 0;
        rd_bits = 0;
        delay = 0;
        cap = '0;
        forever begin
            @(negedge clk);
            if (sclk && !sclk_p) begin      // rising sclk with din stable
                cap = {cap[`ADC_WORD_W-2:0], din};
                cap_n++;
                drdy = 1'b0;                // frame has begun
                if (cap_n == `ADC_WORD_W) begin
                    frames.push_back(cap);
                    cap_n = 0;
                end
            end
            if (!sclk && sclk_p && rd_active) begin  // next result bit after falling sclk
                rd_bits++;
                if (rd_bits == `ADC_WORD_W) begin
                    rd_active = 1'b0;
                    dout = 1'b0;
                end else begin
                    dout = rd_word[`ADC_WORD_W-1-rd_bits];
                end
            end
            if (!start && start_p) begin
                delay = 1 + ({$random(seed)} % 16);  // conversion time
            end else if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    r = $random(seed);
                    rd_word = r[`ADC_WORD_W-1:0];
                    exp_data.push_back(rd_word);
                    drdy = 1'b1;
                    dout = rd_word[`ADC_WORD_W-1];  // msb waits for the first rise
                    rd_active = 1'b1;
                    rd_bits = 0;
                end
            end
            sclk_p = sclk;
            start_p = start;
        end
    end

    // compare process for start width, results and busy end
    always @(negedge clk) begin
        if (rst_l) begin
            if (start) begin
                start_w++;
            end else if (start_q) begin
                check_count("start width", `ADC_START_PULSE, start_w);
                start_w = 0;
            end
            if (rd_en) begin
                if (exp_data.size() == 0) begin
                    $display("%0t: rd_en pulsed with no conversion pending", $time);
                    fail_cnt++;
                end else begin
                    check_word("data_o", exp_data.pop_front(), data_o);
                end
                obs_ch.push_back(channel);
            end
            if (busy_q && !busy)
                check_bit("rd_en before busy fall", 1'b1, rd_q);
            start_q = start;
            busy_q = busy;
            rd_q = rd_en;
        end
    end

    // one sync plus a second sync while busy that must be ignored
    task automatic run_cycle(input chan_sel_t sel, input adc_cfg_t cfg);
        chan_sel_t mask;
        chan_sel_t seen;
        logic      ch;
        int        n_ch;
        int        k;
        mask = (sel == 2'd1) ? 2'b01 : (sel == 2'd2) ? 2'b10 : 2'b11;
        n_ch = (mask == 2'b11) ? 2 : 1;
        seen = '0;
        wreg_command = cfg;
        channel_choice = sel;
        sync = 1'b1;
        @(negedge clk);
        sync = 1'b0;
        check_bit("busy", 1'b1, busy);
        repeat (5) @(negedge clk);
        channel_choice = ~sel;          // the running cycle keeps the choice taken at sync
        sync = 1'b1;
        @(negedge clk);
        sync = 1'b0;
        wait_busy_low(TIMEOUT);
        for (k = 0; k < 8; k++) begin   // no extra cycle from the second sync
            check_bit("busy", 1'b0, busy);
            @(negedge clk);
        end
        if (frames.size() != 3 * n_ch || obs_ch.size() != n_ch) begin
            $display("%0t: choice %0d gave %0d frames and %0d results, expected %0d and %0d",
                     $time, sel, frames.size(), obs_ch.size(), 3 * n_ch, n_ch);
            fail_cnt++;
        end else begin
            for (k = 0; k < n_ch; k++) begin
                ch = (mask == 2'b10) ? 1'b1 : k[0];
                check_word("din write frame", exp_write_frame(ch, cfg), frames.pop_front());
                check_word("din start frame", {`ADC_OP_START, 16'h0000}, frames.pop_front());
                check_word("din read frame", '0, frames.pop_front());
                check_bit("channel", ch, obs_ch[k]);
                seen[obs_ch[k]] = 1'b1;
            end
            check_sel("channel sequence", mask, seen);
        end
        frames.delete();
        obs_ch.delete();
    endtask

    initial begin : stimulus
        logic [31:0] r;
        chan_sel_t   sel;
        int          i;
        rst_l = 1'b0;
        sync = 1'b0;
        wreg_command = '0;
        channel_choice = '0;
        repeat (2) @(negedge clk);
        rst_l = 1'b1;
        for (i = 0; i < 24; i++) begin  // ADC reset pulse after release
            check_bit("nrst", (i < `ADC_NRST_HOLD || i >= `ADC_NRST_HOLD + `ADC_NRST_LOW), nrst);
            check_bit("busy", 1'b0, busy);
            check_bit("rd_en", 1'b0, rd_en);
            @(negedge clk);
        end
        for (i = 0; i < 8; i++) begin   // all four choices followed by random ones
            r = $random(seed);
            sel = (i < 4) ? chan_sel_t'(i) : r[15:14];
            run_cycle(sel, r[13:0]);
        end
        $display("checks done: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== source/adc_cfg.svh ====
`ifndef ADC_CFG_SVH
`define ADC_CFG_SVH

// frame layout, fixed by the ADC register map
`define ADC_WORD_W      24      // serial frame and result word
`define ADC_CFG_W       14      // config bits supplied from outside
`define ADC_MUX_W       2       // channel mux field inside the write frame
`define ADC_OP_W        8       // command opcode

// command opcodes
`define ADC_OP_WREG     8'h14   // register write
`define ADC_OP_START    8'h08   // start conversion

// serial clock: clk cycles per half period of sclk
`define ADC_SCLK_HALF   3

// start pin pulse width in clk cycles
`define ADC_START_PULSE 12

// power-up reset shape on nrst, in clk cycles after rst_l release
`define ADC_NRST_HOLD   4       // high first
`define ADC_NRST_LOW    11      // then low, then high for good

`endif

// ==== source/adc_ctrl_top.sv ====
`timescale 1ns/100ps

// two-channel 24-bit ADC controller
module adc_ctrl_top (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               drdy,            // result ready, from ADC
    input  logic               dout,            // serial data from ADC
    input  logic               sync,            // starts one read cycle
    input  adc_pkg::adc_cfg_t  wreg_command,    // config minus the mux bits
    input  adc_pkg::chan_sel_t channel_choice,  // 0/3 both, 1 first, 2 second
    output logic               din,             // serial data to ADC
    output logic               sclk,
    output logic               nrst,            // ADC reset, active low
    output logic               start,           // ADC start pin
    output logic               busy,
    output adc_pkg::adc_word_t data_o,
    output logic               channel,         // channel of data_o
    output logic               rd_en            // data_o updated
);

    adc_shift_if link ();

    // ADC reset after power-up, runs on its own
    adc_power_reset u_power_reset (
        .clk   (clk),
        .rst_l (rst_l),
        .nrst  (nrst)
    );

    adc_serial_port u_serial_port (
        .clk   (clk),
        .rst_l (rst_l),
        .dout  (dout),
        .din   (din),
        .sclk  (sclk),
        .link  (link)
    );

    adc_sequencer u_sequencer (
        .clk            (clk),
        .rst_l          (rst_l),
        .sync           (sync),
        .drdy           (drdy),
        .wreg_command   (wreg_command),
        .channel_choice (channel_choice),
        .start          (start),
        .busy           (busy),
        .channel        (channel),
        .rd_en          (rd_en),
        .data_o         (data_o),
        .link           (link)
    );

endmodule

// ==== source/adc_pkg.sv ====
`include "adc_cfg.svh"

package adc_pkg;

    // one serial frame, or one conversion result
    typedef logic [`ADC_WORD_W-1:0] adc_word_t;

    // external configuration bits, everything except the mux field
    typedef logic [`ADC_CFG_W-1:0] adc_cfg_t;

    // mux field: 00 selects channel 0, 01 selects channel 1
    typedef logic [`ADC_MUX_W-1:0] adc_mux_t;

    // channel_choice: 0/3 both, 1 first only, 2 second only
    typedef logic [1:0] chan_sel_t;

    // sequencer states, one pass per selected channel
    typedef enum logic [2:0] {
        ST_IDLE,        // wait for sync
        ST_WRITE,       // register write frame on the wire
        ST_START_CMD,   // start command frame on the wire
        ST_START_PULSE, // start pin held high
        ST_DRDY_WAIT,   // conversion running, wait for drdy
        ST_READ,        // result frame shifting in
        ST_NEXT         // pick next channel or finish
    } seq_state_t;

endpackage

// ==== source/adc_power_reset.sv ====
`timescale 1ns/100ps
`include "adc_cfg.svh"

// one reset pulse for the ADC after the controller leaves reset
// nrst: high HOLD cycles, low LOW cycles, then high forever
module adc_power_reset (
    input  logic clk,
    input  logic rst_l,
    output logic nrst
);

    localparam int END_CNT = `ADC_NRST_HOLD + `ADC_NRST_LOW;
    localparam int CNT_W   = $clog2(END_CNT + 1);

    logic [CNT_W-1:0] cnt;   // cycles since release, sticks at END_CNT
    logic             in_low;

    // nrst is registered, so decide one count early
    assign in_low = (cnt >= CNT_W'(`ADC_NRST_HOLD - 1))
                    && (cnt < CNT_W'(END_CNT - 1));

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            cnt  <= '0;
            nrst <= 1'b1;        // ADC not held in reset yet
        end else begin
            if (cnt != CNT_W'(END_CNT))
                cnt <= cnt + 1'b1;
            nrst <= !in_low;
        end
    end

endmodule

// ==== source/adc_sequencer.sv ====
`timescale 1ns/100ps
`include "adc_cfg.svh"

// per channel the FSM writes the config, sends start and pulses the start pin
// then waits for drdy, reads the result and moves to the next channel or idle
module adc_sequencer (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               sync,
    input  logic               drdy,
    input  adc_pkg::adc_cfg_t  wreg_command,
    input  adc_pkg::chan_sel_t channel_choice,
    output logic               start,
    output logic               busy,
    output logic               channel,
    output logic               rd_en,
    output adc_pkg::adc_word_t data_o,
    adc_shift_if.seq           link
);
    import adc_pkg::*;

    localparam int PULSE_W = $clog2(`ADC_START_PULSE + 1);

    seq_state_t         state;
    chan_sel_t          sel_q;      // channel_choice taken at sync
    logic               ch_q;       // channel being worked on
    logic [PULSE_W-1:0] pulse_cnt;  // start pin width
    logic               go_q;
    adc_mux_t           mux;
    logic               more_ch;    // second channel still to do
    logic               port_free;

    assign mux       = adc_mux_t'(ch_q);             // 00 / 01
    assign more_ch   = !ch_q && (sel_q != 2'd1);     // only "first only" stops after ch0
    assign port_free = !link.active;

    assign link.go      = go_q;
    assign link.rx_mode = (state == ST_READ);

    // frame contents follow the state and are valid on the go cycle
    always_comb begin
        case (state)
            ST_WRITE:
                link.tx_word = {`ADC_OP_WREG, mux, wreg_command};
            ST_START_CMD:
                link.tx_word = {`ADC_OP_START, {(`ADC_WORD_W - `ADC_OP_W){1'b0}}};
            default:
                link.tx_word = '0;                    // read frame sends zeros on din
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state     <= ST_IDLE;
            sel_q     <= '0;
            ch_q      <= 1'b0;
            pulse_cnt <= '0;
            go_q      <= 1'b0;
            start     <= 1'b0;
            busy      <= 1'b0;
            channel   <= 1'b0;
            rd_en     <= 1'b0;
        end else begin
            go_q  <= 1'b0;   // strobes
            rd_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (sync) begin
                        sel_q <= channel_choice;
                        ch_q  <= (channel_choice == 2'd2);  // second only starts at ch1
                        busy  <= 1'b1;
                        go_q  <= 1'b1;   // write frame
                        state <= ST_WRITE;
                    end
                end

                ST_WRITE: begin
                    if (link.done) begin
                        go_q  <= 1'b1;   // start command frame
                        state <= ST_START_CMD;
                    end
                end

                ST_START_CMD: begin
                    if (link.done) begin
                        start     <= 1'b1;
                        pulse_cnt <= '0;
                        state     <= ST_START_PULSE;
                    end
                end

                ST_START_PULSE: begin
                    if (pulse_cnt == PULSE_W'(`ADC_START_PULSE - 1)) begin
                        start <= 1'b0;
                        state <= ST_DRDY_WAIT;
                    end else begin
                        pulse_cnt <= pulse_cnt + 1'b1;
                    end
                end

                ST_DRDY_WAIT: begin
                    // drdy is a level and may already be high here
                    if (drdy && port_free) begin
                        go_q  <= 1'b1;   // read frame
                        state <= ST_READ;
                    end
                end

                ST_READ: begin
                    if (link.done) begin
                        rd_en   <= 1'b1;
                        channel <= ch_q;
                        state   <= ST_NEXT;
                    end
                end

                ST_NEXT: begin
                    if (more_ch) begin
                        if (port_free) begin
                            ch_q  <= 1'b1;
                            go_q  <= 1'b1;   // write frame for ch1
                            state <= ST_WRITE;
                        end
                    end else begin
                        busy  <= 1'b0;   // one cycle after the last rd_en
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    start <= 1'b0;
                    busy  <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // result register updated together with rd_en
    always_ff @(posedge clk) begin
        if (state == ST_READ && link.done)
            data_o <= link.rx_word;
    end

endmodule

// ==== source/adc_serial_port.sv ====
`timescale 1ns/100ps
`include "adc_cfg.svh"

// 24-bit serial shifter with sclk from a clk divider
// sclk idles low between frames
// din changes on falling sclk and dout is taken on rising sclk
// bits travel msb first
module adc_serial_port (
    input  logic      clk,
    input  logic      rst_l,
    input  logic      dout,
    output logic      din,
    output logic      sclk,
    adc_shift_if.port link
);
    import adc_pkg::*;

    localparam int HALF_W = $clog2(`ADC_SCLK_HALF + 1);
    localparam int BIT_W  = $clog2(`ADC_WORD_W + 1);

    logic [HALF_W-1:0] half_cnt;  // clk cycles inside one sclk half
    logic [BIT_W-1:0]  bit_cnt;   // falling edges seen so far
    adc_word_t         shreg;     // tx bits out / rx bits in
    logic              active_q;
    logic              done_q;
    logic              rx_q;      // frame type held for the whole frame
    logic              last_fall; // 24 falls done and one tail cycle left
    logic              sclk_tick; // sclk toggles on this edge

    assign last_fall = (bit_cnt == BIT_W'(`ADC_WORD_W));
    assign sclk_tick = active_q && !last_fall
                       && (half_cnt == HALF_W'(`ADC_SCLK_HALF - 1));

    assign link.active  = active_q;
    assign link.done    = done_q;
    assign link.rx_word = shreg;       // complete once done pulses

    // frame control and sclk
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            rx_q     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            sclk     <= 1'b0;
            din      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (link.go) begin
                active_q <= 1'b1;
                rx_q     <= link.rx_mode;
                half_cnt <= HALF_W'(1);  // go cycle counts as first low cycle
                bit_cnt  <= '0;
                // first bit must sit on din before the first rise
                din      <= link.rx_mode ? 1'b0 : link.tx_word[`ADC_WORD_W-1];
            end else if (active_q) begin
                if (last_fall) begin  // tail cycle closes the frame
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end else if (sclk_tick) begin
                    half_cnt <= '0;
                    sclk     <= ~sclk;
                    if (sclk) begin   // falling edge
                        bit_cnt <= bit_cnt + 1'b1;
                        if (rx_q || bit_cnt == BIT_W'(`ADC_WORD_W - 1))
                            din <= 1'b0;                     // read frame or past last bit
                        else
                            din <= shreg[`ADC_WORD_W-2];     // next bit
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

    // shift register for tx and rx bits
    always_ff @(posedge clk) begin
        if (link.go) begin
            shreg <= link.tx_word;
        end else if (sclk_tick) begin
            if (!sclk && rx_q)       // rising edge takes dout
                shreg <= {shreg[`ADC_WORD_W-2:0], dout};
            else if (sclk && !rx_q)  // falling edge moves next tx bit up
                shreg <= {shreg[`ADC_WORD_W-2:0], 1'b0};
        end
    end

endmodule

// ==== source/adc_shift_if.sv ====
`timescale 1ns/100ps

// link between the sequencer and the serial port
interface adc_shift_if;
    import adc_pkg::*;

    logic      go;       // one-cycle frame request, only while !active
    adc_word_t tx_word;  // word to send, sampled with go
    logic      rx_mode;  // 1: read frame, din held low
    logic      active;   // frame in progress
    logic      done;     // one-cycle end of frame
    adc_word_t rx_word;  // received word, valid with done

    // frame requester side
    modport seq (
        output go,
        output tx_word,
        output rx_mode,
        input  active,
        input  done,
        input  rx_word
    );

    // shifter side
    modport port (
        input  go,
        input  tx_word,
        input  rx_mode,
        output active,
        output done,
        output rx_word
    );

endinterface

// ==== src.f ====
+incdir+source
source/adc_pkg.sv
source/adc_shift_if.sv
source/adc_serial_port.sv
source/adc_power_reset.sv
source/adc_sequencer.sv
source/adc_ctrl_top.sv
sim/adc_ctrl_props.sv
sim/adc_ctrl_tb.sv
